//--- pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// data word width
`define DATA_W 32

// register file geometry
`define NUM_REGS 32
`define REG_AW 5

// data memory depth in words
`define DMEM_WORDS 64

`endif

//--- pipe_pkg.sv
`default_nettype none

`include "pipe_settings.svh"

package pipe_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_addi,
        op_lw,
        op_sw,
        op_nop
    } pipe_op_t;

    // decode to execute
    typedef struct packed {
        pipe_op_t    op;
        reg_addr_t   rs;
        reg_addr_t   rt;     // also the store data register
        reg_addr_t   rd;
        logic [15:0] imm;    // sign-extended in execute
        word_t       rs_val;
        word_t       rt_val;
    } es_payload_t;

    // execute to memory
    typedef struct packed {
        pipe_op_t  op;
        reg_addr_t dest;
        logic      reg_we;
        word_t     result;   // alu result or byte address
        word_t     store_data;
    } ms_payload_t;

    // memory to writeback
    typedef struct packed {
        reg_addr_t dest;
        logic      reg_we;
        word_t     result;
    } ws_payload_t;

endpackage

`default_nettype wire

//--- reg_file.sv
`default_nettype none

`include "pipe_settings.svh"

module reg_file
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    input  logic [`REG_AW-1:0] waddr,
    input  logic              we,
    input  logic [`DATA_W-1:0] wdata,
    output logic [`DATA_W-1:0] rdata1,
    output logic [`DATA_W-1:0] rdata2
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // no write-to-read bypass here, the top level handles it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- fwd_unit.sv
`default_nettype none

`include "pipe_settings.svh"

module fwd_unit
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [`REG_AW-1:0] ds_raddr1,
    input  logic [`REG_AW-1:0] ds_raddr2,
    input  logic [`REG_AW-1:0] es_dest,
    input  logic [`REG_AW-1:0] es_store_src,
    input  logic [`REG_AW-1:0] ms_dest,
    input  logic              es_reg_we,
    input  logic              es_mem_we,
    input  logic              ms_reg_we,
    output logic              src1_from_ms,
    output logic              src1_from_ws,
    output logic              src2_from_ms,
    output logic              src2_from_ws,
    output logic              store_from_ws
);

    // summaries one stage on, so they describe execute, memory and writeback
    reg_addr_t ds_raddr1_r;
    reg_addr_t ds_raddr2_r;
    reg_addr_t es_dest_r;
    reg_addr_t es_store_src_r;
    reg_addr_t ms_dest_r;
    logic      es_reg_we_r;
    logic      es_mem_we_r;
    logic      ms_reg_we_r;

    logic      ms_writes;
    logic      ws_writes;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_raddr1_r    <= '0;
            ds_raddr2_r    <= '0;
            es_dest_r      <= '0;
            es_store_src_r <= '0;
            es_reg_we_r    <= 1'b0;
            es_mem_we_r    <= 1'b0;
            ms_dest_r      <= '0;
            ms_reg_we_r    <= 1'b0;
        end else begin
            ds_raddr1_r    <= ds_raddr1;
            ds_raddr2_r    <= ds_raddr2;
            es_dest_r      <= es_dest;
            es_store_src_r <= es_store_src;
            es_reg_we_r    <= es_reg_we;
            es_mem_we_r    <= es_mem_we;
            ms_dest_r      <= ms_dest;
            ms_reg_we_r    <= ms_reg_we;
        end
    end

    assign ms_writes = es_reg_we_r && (es_dest_r != '0);
    assign ws_writes = ms_reg_we_r && (ms_dest_r != '0);

    // nearer producer wins
    assign src1_from_ms  = ms_writes && (es_dest_r == ds_raddr1_r);
    assign src2_from_ms  = ms_writes && (es_dest_r == ds_raddr2_r);
    assign src1_from_ws  = ws_writes && (ms_dest_r == ds_raddr1_r) && !src1_from_ms;
    assign src2_from_ws  = ws_writes && (ms_dest_r == ds_raddr2_r) && !src2_from_ms;
    assign store_from_ws = ws_writes && es_mem_we_r && (ms_dest_r == es_store_src_r);

endmodule

`default_nettype wire

//--- stage_latch.sv
`default_nettype none

module stage_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload is don't-care while out_valid is low
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

`default_nettype wire

//--- exec_unit.sv
`default_nettype none

`include "pipe_settings.svh"

module exec_unit
    import pipe_pkg::*;
(
    input  pipe_op_t          op,
    input  logic [`DATA_W-1:0] rf_a,
    input  logic [`DATA_W-1:0] rf_b,
    input  logic [`DATA_W-1:0] ms_fwd,
    input  logic [`DATA_W-1:0] ws_fwd,
    input  logic [15:0]       imm,
    input  logic              src1_from_ms,
    input  logic              src1_from_ws,
    input  logic              src2_from_ms,
    input  logic              src2_from_ws,
    output logic [`DATA_W-1:0] result,
    output logic [`DATA_W-1:0] store_data
);

    word_t imm_ext;
    word_t op_a;
    word_t op_b;

    assign imm_ext = {{(`DATA_W-16){imm[15]}}, imm};

    always_comb begin
        if (src1_from_ms)      op_a = ms_fwd;
        else if (src1_from_ws) op_a = ws_fwd;
        else                   op_a = rf_a;
    end

    always_comb begin
        if (src2_from_ms)      op_b = ms_fwd;
        else if (src2_from_ws) op_b = ws_fwd;
        else                   op_b = rf_b;
    end

    always_comb begin
        case (op)
            op_add:  result = op_a + op_b;
            op_sub:  result = op_a - op_b;
            op_and:  result = op_a & op_b;
            op_or:   result = op_a | op_b;
            op_addi,
            op_lw,
            op_sw:   result = op_a + imm_ext;   // immediate or address
            default: result = '0;
        endcase
    end

    assign store_data = op_b;

endmodule

`default_nettype wire

//--- data_mem.sv
`default_nettype none

`include "pipe_settings.svh"

module data_mem
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [`DATA_W-1:0] addr,
    input  logic              we,
    input  logic [`DATA_W-1:0] wdata,
    output logic [`DATA_W-1:0] rdata
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    word_t             mem [`DMEM_WORDS];
    logic [IDX_W-1:0]  idx;

    assign idx = addr[IDX_W+1:2];   // word index, upper bits wrap

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- int_pipe.sv
`default_nettype none

`include "pipe_settings.svh"

module int_pipe
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  pipe_op_t          in_op,
    input  logic [`REG_AW-1:0] in_rs,
    input  logic [`REG_AW-1:0] in_rt,
    input  logic [`REG_AW-1:0] in_rd,
    input  logic [15:0]       in_imm,
    output logic              wb_valid,
    output logic [`REG_AW-1:0] wb_dest,
    output logic [`DATA_W-1:0] wb_data
);

    es_payload_t ds_data, es_data;
    ms_payload_t ms_in, ms_data;
    ws_payload_t ws_in, ws_data;
    logic        es_valid, ms_valid, ws_valid;

    word_t rf_rdata1, rf_rdata2;
    word_t exec_result, exec_store_data;
    word_t dmem_rdata, ms_result, dmem_wdata;

    logic src1_from_ms, src1_from_ws, src2_from_ms, src2_from_ws, store_from_ws;
    logic es_reg_we, es_mem_we, ms_reg_we, ms_mem_we;

    // decode, with the retiring write bypassed into the read values
    always_comb begin
        ds_data.op     = in_op;
        ds_data.rs     = in_rs;
        ds_data.rt     = in_rt;
        ds_data.rd     = in_rd;
        ds_data.imm    = in_imm;
        ds_data.rs_val = (wb_valid && wb_dest == in_rs) ? wb_data : rf_rdata1;
        ds_data.rt_val = (wb_valid && wb_dest == in_rt) ? wb_data : rf_rdata2;
    end

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .raddr1(in_rs), .raddr2(in_rt),
        .waddr(wb_dest), .we(wb_valid), .wdata(wb_data),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    stage_latch #(.payload_t(es_payload_t)) u_es_latch (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_data(ds_data),
        .out_valid(es_valid), .out_data(es_data)
    );

    // bubbles never write or forward
    assign es_reg_we = es_valid && ms_in.reg_we;
    assign es_mem_we = es_valid && (es_data.op == op_sw);
    assign ms_reg_we = ms_valid && ms_data.reg_we;
    assign ms_mem_we = ms_valid && (ms_data.op == op_sw);

    fwd_unit u_fwd_unit (
        .clk(clk), .reset(reset),
        .ds_raddr1(in_rs), .ds_raddr2(in_rt),
        .es_dest(es_data.rd), .es_store_src(es_data.rt), .ms_dest(ms_data.dest),
        .es_reg_we(es_reg_we), .es_mem_we(es_mem_we), .ms_reg_we(ms_reg_we),
        .src1_from_ms(src1_from_ms), .src1_from_ws(src1_from_ws),
        .src2_from_ms(src2_from_ms), .src2_from_ws(src2_from_ws),
        .store_from_ws(store_from_ws)
    );

    exec_unit u_exec_unit (
        .op(es_data.op), .rf_a(es_data.rs_val), .rf_b(es_data.rt_val),
        .ms_fwd(ms_result), .ws_fwd(ws_data.result), .imm(es_data.imm),
        .src1_from_ms(src1_from_ms), .src1_from_ws(src1_from_ws),
        .src2_from_ms(src2_from_ms), .src2_from_ws(src2_from_ws),
        .result(exec_result), .store_data(exec_store_data)
    );

    assign ms_in.op         = es_data.op;
    assign ms_in.dest       = es_data.rd;
    assign ms_in.reg_we     = es_data.op inside {op_add, op_sub, op_and, op_or, op_addi, op_lw};
    assign ms_in.result     = exec_result;
    assign ms_in.store_data = exec_store_data;

    stage_latch #(.payload_t(ms_payload_t)) u_ms_latch (
        .clk(clk), .reset(reset),
        .in_valid(es_valid), .in_data(ms_in),
        .out_valid(ms_valid), .out_data(ms_data)
    );

    assign dmem_wdata = store_from_ws ? ws_data.result : ms_data.store_data;

    data_mem u_data_mem (
        .clk(clk), .reset(reset),
        .addr(ms_data.result), .we(ms_mem_we), .wdata(dmem_wdata),
        .rdata(dmem_rdata)
    );

    assign ms_result = (ms_data.op == op_lw) ? dmem_rdata : ms_data.result;

    assign ws_in.dest   = ms_data.dest;
    assign ws_in.reg_we = ms_reg_we;
    assign ws_in.result = ms_result;

    stage_latch #(.payload_t(ws_payload_t)) u_ws_latch (
        .clk(clk), .reset(reset),
        .in_valid(ms_valid), .in_data(ws_in),
        .out_valid(ws_valid), .out_data(ws_data)
    );

    assign wb_valid = ws_valid && ws_data.reg_we && (ws_data.dest != '0);
    assign wb_dest  = ws_data.dest;
    assign wb_data  = ws_data.result;

endmodule

`default_nettype wire

//--- tb_int_pipe.sv
`default_nettype none

`include "pipe_settings.svh"

module tb_int_pipe
    import pipe_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_COUNT      = 400;
    localparam int DIRECTED_CYCLES = 250;
    localparam int TIMEOUT_NS      = (RAND_COUNT + DIRECTED_CYCLES) * 8 + 2000;

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid;
    pipe_op_t  in_op;
    reg_addr_t in_rs, in_rt, in_rd;
    logic [15:0] in_imm;
    logic      wb_valid;
    reg_addr_t wb_dest;
    word_t     wb_data;

    word_t     model_regs [`NUM_REGS];
    word_t     model_mem [`DMEM_WORDS];
    reg_addr_t exp_dest [$];
    word_t     exp_data [$];
    int        exp_cycle [$];
    reg_addr_t e_dest;
    word_t     e_data;
    int        e_cycle;
    int        cycle = 0;
    int        errors = 0;
    int        checked = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        test_start_errors = 0;

    int_pipe DUT (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_op(in_op), .in_rs(in_rs), .in_rt(in_rt),
        .in_rd(in_rd), .in_imm(in_imm),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // architectural model, updated in program order as each instruction is driven
    task automatic issue(input pipe_op_t op, input reg_addr_t rs, input reg_addr_t rt,
                         input reg_addr_t rd, input logic [15:0] imm);
        word_t a;
        word_t b;
        word_t res;
        int    idx;
        logic  writes;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_op    = op;
        in_rs    = rs;
        in_rt    = rt;
        in_rd    = rd;
        in_imm   = imm;
        a = model_regs[rs];
        b = model_regs[rt];
        idx = ((a + {{16{imm[15]}}, imm}) >> 2) % `DMEM_WORDS;
        writes = 1'b1;
        res = '0;
        case (op)
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_addi: res = a + {{16{imm[15]}}, imm};
            op_lw:   res = model_mem[idx];
            op_sw: begin
                model_mem[idx] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != '0) begin
            model_regs[rd] = res;
            exp_dest.push_back(rd);
            exp_data.push_back(res);
            exp_cycle.push_back(cycle + 3);   // retires in the third cycle
        end
    endtask

    task automatic bubble();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_op    = op_nop;
    endtask

    task automatic end_test(input string name);
        repeat (6) bubble();
        assert (exp_dest.size() == 0) else begin
            $display("%0d writebacks never appeared in test %s", exp_dest.size(), name);
            errors++;
            exp_dest.delete();
            exp_data.delete();
            exp_cycle.delete();
        end
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    function automatic reg_addr_t pick_reg();
        if ($urandom_range(0, 7) == 0) return reg_addr_t'($urandom_range(0, `NUM_REGS - 1));
        return reg_addr_t'($urandom_range(0, 7));   // small range keeps hazards dense
    endfunction

    function automatic logic [15:0] mem_imm();
        return 16'($urandom_range(0, `DMEM_WORDS - 1) * 4);
    endfunction

    // every retired write is compared with the head of the expected queue
    always @(negedge clk) begin
        if (!reset && wb_valid === 1'b1) begin
            assert (exp_dest.size() != 0) else begin
                $display("writeback to r%0d at %0t appeared with nothing outstanding",
                         wb_dest, $time);
                errors++;
            end
            if (exp_dest.size() != 0) begin
                e_dest  = exp_dest.pop_front();
                e_data  = exp_data.pop_front();
                e_cycle = exp_cycle.pop_front();
                checked++;
                assert (wb_dest == e_dest && wb_data == e_data) else begin
                    $display("FAIL %0t: writeback r%0d = %h, expected r%0d = %h",
                             $time, wb_dest, wb_data, e_dest, e_data);
                    errors++;
                end
                assert (cycle == e_cycle) else begin
                    $display("FAIL %0t: r%0d retired in cycle %0d, expected cycle %0d",
                             $time, wb_dest, cycle, e_cycle);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int        kind;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'had7a_5aee));
        for (int i = 0; i < `NUM_REGS; i++) model_regs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++) model_mem[i] = '0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = op_nop;
        in_rs    = '0;
        in_rt    = '0;
        in_rd    = '0;
        in_imm   = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (wb_valid == 1'b0) else begin
            $display("FAIL %0t: wb_valid high right after reset", $time);
            errors++;
        end

        for (int i = 0; i < 12; i++) begin   // independent ops, bubbles between
            kind = $urandom_range(0, 4);
            rs = reg_addr_t'($urandom_range(1, 7));
            rt = reg_addr_t'($urandom_range(1, 7));
            rd = reg_addr_t'($urandom_range(1, 7));
            case (kind)
                0: issue(op_add, rs, rt, rd, '0);
                1: issue(op_sub, rs, rt, rd, '0);
                2: issue(op_and, rs, rt, rd, '0);
                3: issue(op_or, rs, rt, rd, '0);
                default: issue(op_addi, rs, rt, rd, 16'($urandom));
            endcase
            repeat (3) bubble();
        end
        end_test("alu without dependencies");

        issue(op_addi, 5'd0, 5'd0, 5'd4, 16'd11);
        issue(op_add, 5'd4, 5'd4, 5'd5, '0);          // distance one
        issue(op_addi, 5'd0, 5'd0, 5'd6, 16'd3);
        issue(op_or, 5'd1, 5'd1, 5'd20, '0);
        issue(op_sub, 5'd5, 5'd6, 5'd7, '0);          // distance two on rt
        issue(op_addi, 5'd0, 5'd0, 5'd8, 16'd1);
        issue(op_addi, 5'd0, 5'd0, 5'd8, 16'd2);
        issue(op_add, 5'd8, 5'd8, 5'd9, '0);          // nearer r8 wins
        end_test("forwarding distance one and two");

        issue(op_addi, 5'd0, 5'd0, 5'd10, 16'h0055);
        issue(op_sw, 5'd0, 5'd10, 5'd0, 16'd16);
        issue(op_lw, 5'd0, 5'd0, 5'd11, 16'd16);
        issue(op_add, 5'd11, 5'd11, 5'd12, '0);       // load-use, no stall
        issue(op_sub, 5'd12, 5'd11, 5'd13, '0);
        end_test("load use");

        issue(op_addi, 5'd0, 5'd0, 5'd13, 16'd77);
        issue(op_sw, 5'd0, 5'd13, 5'd0, 16'd20);
        issue(op_addi, 5'd0, 5'd0, 5'd17, 16'hfffd);
        issue(op_addi, 5'd0, 5'd0, 5'd18, 16'd1);
        issue(op_sw, 5'd0, 5'd17, 5'd0, 16'd24);
        issue(op_lw, 5'd0, 5'd0, 5'd14, 16'd20);
        issue(op_lw, 5'd0, 5'd0, 5'd19, 16'd24);
        issue(op_add, 5'd14, 5'd19, 5'd15, '0);
        end_test("store data forwarding");

        issue(op_addi, 5'd0, 5'd0, 5'd0, 16'd99);
        issue(op_add, 5'd0, 5'd0, 5'd15, '0);
        issue(op_lw, 5'd0, 5'd0, 5'd0, 16'd20);
        issue(op_or, 5'd0, 5'd0, 5'd16, '0);
        issue(op_addi, 5'd0, 5'd0, 5'd21, 16'd5);
        end_test("register zero");

        for (int i = 0; i < RAND_COUNT; i++) begin
            kind = $urandom_range(0, 9);
            rs = pick_reg();
            rt = pick_reg();
            rd = pick_reg();
            case (kind)
                0: issue(op_add, rs, rt, rd, '0);
                1: issue(op_sub, rs, rt, rd, '0);
                2: issue(op_and, rs, rt, rd, '0);
                3: issue(op_or, rs, rt, rd, '0);
                4: issue(op_addi, rs, rt, rd, 16'($urandom));
                5: issue(op_lw, '0, rt, rd, mem_imm());
                6: issue(op_sw, '0, rt, rd, mem_imm());
                7: issue(op_nop, rs, rt, rd, '0);
                default: bubble();
            endcase
        end
        end_test("random mixed stream");

        $display("tests %0d, failed %0d, writebacks checked %0d, errors %0d",
                 tests_run, tests_failed, checked, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
pipe_pkg.sv
reg_file.sv
fwd_unit.sv
stage_latch.sv
exec_unit.sv
data_mem.sv
int_pipe.sv
tb_int_pipe.sv

//--- Bender.yml
package:
  name: int_pipe

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pipe_pkg.sv
      - reg_file.sv
      - fwd_unit.sv
      - stage_latch.sv
      - exec_unit.sv
      - data_mem.sv
      - int_pipe.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_int_pipe.sv
